//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module trace_unit_tb \
  -f trace_unit.f \
  --Mdir obj_dir -o trace_unit_sim

status=0
./obj_dir/trace_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- src/hart_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module hart_tracker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n,
  input  wire logic                   dec_push,
  input  wire logic                   ex_adv,
  input  wire logic                   wb_adv,
  input  wire trace_pkg::decode_rec_t dec_rec,
  input  wire logic                   mem_valid,
  input  wire logic                   mem_we,
  input  wire rv_isa_pkg::xlen_t      mem_addr,
  input  wire logic                   reg_we,
  input  wire rv_isa_pkg::reg_addr_t  reg_addr,
  input  wire rv_isa_pkg::xlen_t      reg_wdata,
  input  wire logic                   ret_pop,
  output logic                        ret_valid,
  output trace_pkg::retire_rec_t      ret_rec,
  output logic                        overflow
);

  import rv_isa_pkg::*;
  import trace_pkg::*;

  decode_rec_t dq_rdata;
  exec_rec_t   eq_wdata;
  exec_rec_t   eq_rdata;
  retire_rec_t rq_wdata;
  logic        dq_empty;
  logic        dq_full;
  logic        eq_empty;
  logic        eq_full;
  logic        rq_empty;
  logic        rq_full;
  logic        dq_push;
  logic        eq_req;
  logic        eq_push;
  logic        rq_req;
  logic        rq_push;
  logic        drop;
  reg_addr_t   rd;
  logic        rd_hit;

  // --------------------
  // Decode queue, the execute advance pops the head
  assign dq_push = dec_push && (!dq_full || ex_adv);

  trace_fifo #(.payload_t(decode_rec_t), .DEPTH(`TRACE_FIFO_DEPTH)) u_dec_q (
    .clk_i (clk_i),
    .rst_n (rst_n),
    .push  (dq_push),
    .wdata (dec_rec),
    .pop   (ex_adv),
    .rdata (dq_rdata),
    .empty (dq_empty),
    .full  (dq_full)
  );

  // --------------------
  // Execute queue, head of decode plus the memory access
  assign eq_req   = ex_adv && !dq_empty;
  assign eq_push  = eq_req && (!eq_full || wb_adv);
  assign eq_wdata = '{dec: dq_rdata, mem_valid: mem_valid, mem_we: mem_we, mem_addr: mem_addr};

  trace_fifo #(.payload_t(exec_rec_t), .DEPTH(`TRACE_FIFO_DEPTH)) u_exec_q (
    .clk_i (clk_i),
    .rst_n (rst_n),
    .push  (eq_push),
    .wdata (eq_wdata),
    .pop   (wb_adv),
    .rdata (eq_rdata),
    .empty (eq_empty),
    .full  (eq_full)
  );

  // --------------------
  // Retire queue
  // Write kept only when it targets this instruction's rd, never x0
  assign rd       = rd_of(eq_rdata.dec.instr);
  assign rd_hit   = reg_we && (reg_addr == rd) && (rd != '0);
  assign rq_req   = wb_adv && !eq_empty;
  assign rq_push  = rq_req && (!rq_full || ret_pop);
  assign rq_wdata = '{ex: eq_rdata, rd_we: rd_hit, rd: rd, rd_wdata: rd_hit ? reg_wdata : '0};

  trace_fifo #(.payload_t(retire_rec_t), .DEPTH(`TRACE_FIFO_DEPTH)) u_ret_q (
    .clk_i (clk_i),
    .rst_n (rst_n),
    .push  (rq_push),
    .wdata (rq_wdata),
    .pop   (ret_pop),
    .rdata (ret_rec),
    .empty (rq_empty),
    .full  (rq_full)
  );

  assign ret_valid = !rq_empty;

  // Any refused push loses an instruction, flag stays until reset
  assign drop = (dec_push && !dq_push) || (eq_req && !eq_push) || (rq_req && !rq_push);

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) overflow <= 1'b0;
    else if (drop) overflow <= 1'b1;
  end

  // Bus ordering per hart, seen through the capture stage
  a_ex_order: assert property (@(posedge clk_i) disable iff (!rst_n) ex_adv |-> !dq_empty)
    else $error("hart_tracker: execute with nothing decoded");
  a_wb_order: assert property (@(posedge clk_i) disable iff (!rst_n) wb_adv |-> !eq_empty)
    else $error("hart_tracker: writeback with nothing executed");

endmodule

`default_nettype wire

//--- src/retire_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module retire_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n,
  input  wire logic [`TRACE_NUM_HARTS-1:0] ret_valid,
  input  wire trace_pkg::retire_rec_t ret_rec [`TRACE_NUM_HARTS],
  input  wire logic                   trace_ack,
  output logic [`TRACE_NUM_HARTS-1:0] ret_pop,
  output logic                        trace_req,
  output rv_isa_pkg::hart_id_t        trace_hart,
  output trace_pkg::cycle_t           trace_cycle,
  output rv_isa_pkg::xlen_t           trace_pc,
  output rv_isa_pkg::xlen_t           trace_instr,
  output rv_isa_pkg::instr_kind_e     trace_kind,
  output logic                        trace_rd_we,
  output rv_isa_pkg::reg_addr_t       trace_rd,
  output rv_isa_pkg::xlen_t           trace_rd_wdata,
  output logic                        trace_mem_valid,
  output logic                        trace_mem_we,
  output rv_isa_pkg::xlen_t           trace_mem_addr
);

  import rv_isa_pkg::*;
  import trace_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_ACK_LOW} state_e;

  state_e      state_q;
  logic        pend_q;
  hart_id_t    last_q;
  hart_id_t    win;
  logic        any_valid;
  logic        do_pop;
  retire_rec_t rec_q;
  hart_id_t    hart_q;

  // Round-robin search, starts after the last hart served
  always_comb begin
    int unsigned idx;
    win       = last_q;
    any_valid = 1'b0;
    for (int unsigned i = 1; i <= `TRACE_NUM_HARTS; i++) begin
      idx = (int'(last_q) + i) % `TRACE_NUM_HARTS;
      if (!any_valid && ret_valid[idx]) begin
        any_valid = 1'b1;
        win       = hart_id_t'(idx);
      end
    end
  end

  // Output register refills once the previous record was acked
  always_comb begin
    case (state_q)
      S_IDLE:    do_pop = any_valid && !trace_ack;
      S_ACK_LOW: do_pop = any_valid && !pend_q;
      default:   do_pop = 1'b0;
    endcase
  end

  always_comb begin
    ret_pop = '0;
    if (do_pop) ret_pop[win] = 1'b1;
  end

  // --------------------
  // Four-phase handshake
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      pend_q  <= 1'b0;
      last_q  <= '0;
    end else begin
      if (do_pop) last_q <= win;
      case (state_q)
        S_IDLE:  if (do_pop) state_q <= S_REQ;
        S_REQ:   if (trace_ack) state_q <= S_ACK_LOW;
        S_ACK_LOW: begin
          if (!trace_ack) begin
            // Pending record goes out as soon as ack is low
            pend_q  <= 1'b0;
            state_q <= (pend_q || do_pop) ? S_REQ : S_IDLE;
          end else if (do_pop) begin
            pend_q <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Record payload held stable while the request is up
  always_ff @(posedge clk_i) begin
    if (do_pop) begin
      rec_q  <= ret_rec[win];
      hart_q <= win;
    end
  end

  assign trace_req       = (state_q == S_REQ);
  assign trace_hart      = hart_q;
  assign trace_cycle     = rec_q.ex.dec.cycle;
  assign trace_pc        = rec_q.ex.dec.pc;
  assign trace_instr     = rec_q.ex.dec.instr;
  assign trace_kind      = instr_kind_of(rec_q.ex.dec.instr);
  assign trace_rd_we     = rec_q.rd_we;
  assign trace_rd        = rec_q.rd;
  assign trace_rd_wdata  = rec_q.rd_wdata;
  assign trace_mem_valid = rec_q.ex.mem_valid;
  assign trace_mem_we    = rec_q.ex.mem_we;
  assign trace_mem_addr  = rec_q.ex.mem_addr;

  // New request only after the receiver let go of ack
  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_n)
    $rose(trace_req) |-> !$past(trace_ack))
    else $error("retire_arbiter: request raised while ack high");

endmodule

`default_nettype wire

//--- src/rv_isa_pkg.sv
`default_nettype none

`include "trace_cfg.svh"

package rv_isa_pkg;

  // Hart tag width, at least one bit
  localparam int unsigned HART_W = (`TRACE_NUM_HARTS > 1) ? $clog2(`TRACE_NUM_HARTS) : 1;

  typedef logic [31:0]       xlen_t;
  typedef logic [4:0]        reg_addr_t;
  typedef logic [6:0]        opcode_t;
  typedef logic [HART_W-1:0] hart_id_t;

  // Coarse class of a retired instruction
  typedef enum logic [1:0] {
    KIND_LOAD  = 2'd0,
    KIND_STORE = 2'd1,
    KIND_ALU   = 2'd2,
    KIND_OTHER = 2'd3
  } instr_kind_e;

  // --------------------
  // Major opcodes
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  // Kind from the opcode field only
  function automatic instr_kind_e instr_kind_of(input xlen_t instr);
    instr_kind_e kind;
    case (opcode_t'(instr[6:0]))
      OPC_LOAD:   kind = KIND_LOAD;
      OPC_STORE:  kind = KIND_STORE;
      OPC_OP,
      OPC_OP_IMM,
      OPC_LUI,
      OPC_AUIPC:  kind = KIND_ALU;
      default:    kind = KIND_OTHER;
    endcase
    return kind;
  endfunction

  // Destination register field
  function automatic reg_addr_t rd_of(input xlen_t instr);
    return instr[11:7];
  endfunction

endpackage

`default_nettype wire

//--- src/trace_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module trace_capture (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n,
  // Decode event
  input  wire logic                        id_fire,
  input  wire rv_isa_pkg::hart_id_t        id_hart,
  input  wire rv_isa_pkg::xlen_t           id_pc,
  input  wire rv_isa_pkg::xlen_t           id_instr,
  input  wire logic                        id_illegal,
  // Execute event with optional memory access
  input  wire logic                        ex_fire,
  input  wire rv_isa_pkg::hart_id_t        ex_hart,
  input  wire logic                        mem_fire,
  input  wire logic                        mem_we,
  input  wire rv_isa_pkg::xlen_t           mem_addr,
  // Writeback event
  input  wire logic                        wb_fire,
  input  wire rv_isa_pkg::hart_id_t        wb_hart,
  input  wire logic                        wb_reg_we,
  input  wire rv_isa_pkg::reg_addr_t       wb_reg_addr,
  input  wire rv_isa_pkg::xlen_t           wb_reg_wdata,
  // Per-hart strobes
  output logic [`TRACE_NUM_HARTS-1:0]      dec_push,
  output logic [`TRACE_NUM_HARTS-1:0]      ex_adv,
  output logic [`TRACE_NUM_HARTS-1:0]      wb_adv,
  // Shared registered data
  output trace_pkg::decode_rec_t           dec_rec,
  output logic                             mem_valid,
  output logic                             cap_mem_we,
  output rv_isa_pkg::xlen_t                cap_mem_addr,
  output logic                             reg_we,
  output rv_isa_pkg::reg_addr_t            reg_addr,
  output rv_isa_pkg::xlen_t                reg_wdata
);

  import rv_isa_pkg::*;
  import trace_pkg::*;

  cycle_t cycle_q;

  // Free running stamp, 0 at the first edge after reset
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) cycle_q <= '0;
    else cycle_q <= cycle_q + 1'b1;
  end

  // --------------------
  // One-hot strobes per hart, illegal decodes never reach a tracker
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      dec_push <= '0;
      ex_adv   <= '0;
      wb_adv   <= '0;
    end else begin
      for (int h = 0; h < `TRACE_NUM_HARTS; h++) begin
        dec_push[h] <= id_fire && !id_illegal && (id_hart == hart_id_t'(h));
        ex_adv[h]   <= ex_fire && (ex_hart == hart_id_t'(h));
        wb_adv[h]   <= wb_fire && (wb_hart == hart_id_t'(h));
      end
    end
  end

  // Data only matters alongside a strobe
  always_ff @(posedge clk_i) begin
    dec_rec      <= '{cycle: cycle_q, pc: id_pc, instr: id_instr};
    // Memory fields cleared when execute had no access
    mem_valid    <= ex_fire && mem_fire;
    cap_mem_we   <= ex_fire && mem_fire && mem_we;
    cap_mem_addr <= (ex_fire && mem_fire) ? mem_addr : '0;
    reg_we       <= wb_fire && wb_reg_we;
    reg_addr     <= wb_reg_addr;
    reg_wdata    <= wb_reg_wdata;
  end

  // Tags outside the cluster would be silently lost
  a_hart_range: assert property (@(posedge clk_i) disable iff (!rst_n)
    (id_fire -> (int'(id_hart) < `TRACE_NUM_HARTS)) &&
    (ex_fire -> (int'(ex_hart) < `TRACE_NUM_HARTS)) &&
    (wb_fire -> (int'(wb_hart) < `TRACE_NUM_HARTS)))
    else $error("trace_capture: hart tag out of range");

endmodule

`default_nettype wire

//--- src/trace_cfg.svh
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Harts sharing the observation bus
// Sets the hart tag width and the tracker count
`define TRACE_NUM_HARTS 2

// Entries in each per-hart tracking queue
`define TRACE_FIFO_DEPTH 4

// Width of the decode cycle stamp, wraps silently
`define TRACE_CYCLE_W 16

`endif

//--- src/trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module trace_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n,
  input  wire logic     push,
  input  wire payload_t wdata,
  input  wire logic     pop,
  output payload_t      rdata,
  output logic          empty,
  output logic          full
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (count_q == '0);
  assign full    = (count_q == CW'(DEPTH));
  assign do_pop  = pop && !empty;
  // A full queue still takes a push when the head leaves in the same cycle
  assign do_push = push && (!full || do_pop);
  // Head entry shown combinationally
  assign rdata   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= wdata;
  end

  // Callers must never pop an empty queue
  a_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n) pop |-> !empty)
    else $error("trace_fifo: pop while empty");
  // Callers filter pushes into a full queue
  a_push_full: assert property (@(posedge clk_i) disable iff (!rst_n) push && full |-> pop)
    else $error("trace_fifo: push while full");

endmodule

`default_nettype wire

//--- src/trace_pkg.sv
`default_nettype none

`include "trace_cfg.svh"

package trace_pkg;

  typedef logic [`TRACE_CYCLE_W-1:0] cycle_t;

  // --------------------
  // Record built at decode
  typedef struct packed {
    cycle_t            cycle;
    rv_isa_pkg::xlen_t pc;
    rv_isa_pkg::xlen_t instr;
  } decode_rec_t;

  // Decode record plus the memory access seen in execute
  // Fields are zero when there was no access
  typedef struct packed {
    decode_rec_t       dec;
    logic              mem_valid;
    logic              mem_we;
    rv_isa_pkg::xlen_t mem_addr;
  } exec_rec_t;

  // Execute record plus the register write seen in writeback
  typedef struct packed {
    exec_rec_t             ex;
    logic                  rd_we;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::xlen_t     rd_wdata;
  } retire_rec_t;

endpackage

`default_nettype wire

//--- src/trace_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module trace_unit (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n,
  // Decode event
  input  wire logic                   id_fire,
  input  wire rv_isa_pkg::hart_id_t   id_hart,
  input  wire rv_isa_pkg::xlen_t      id_pc,
  input  wire rv_isa_pkg::xlen_t      id_instr,
  input  wire logic                   id_illegal,
  // Execute event with optional memory access
  input  wire logic                   ex_fire,
  input  wire rv_isa_pkg::hart_id_t   ex_hart,
  input  wire logic                   mem_fire,
  input  wire logic                   mem_we,
  input  wire rv_isa_pkg::xlen_t      mem_addr,
  // Writeback event
  input  wire logic                   wb_fire,
  input  wire rv_isa_pkg::hart_id_t   wb_hart,
  input  wire logic                   wb_reg_we,
  input  wire rv_isa_pkg::reg_addr_t  wb_reg_addr,
  input  wire rv_isa_pkg::xlen_t      wb_reg_wdata,
  // Retired record, four-phase
  output logic                        trace_req,
  input  wire logic                   trace_ack,
  output rv_isa_pkg::hart_id_t        trace_hart,
  output trace_pkg::cycle_t           trace_cycle,
  output rv_isa_pkg::xlen_t           trace_pc,
  output rv_isa_pkg::xlen_t           trace_instr,
  output rv_isa_pkg::instr_kind_e     trace_kind,
  output logic                        trace_rd_we,
  output rv_isa_pkg::reg_addr_t       trace_rd,
  output rv_isa_pkg::xlen_t           trace_rd_wdata,
  output logic                        trace_mem_valid,
  output logic                        trace_mem_we,
  output rv_isa_pkg::xlen_t           trace_mem_addr,
  // Sticky, one bit per hart
  output logic [`TRACE_NUM_HARTS-1:0] trace_overflow
);

  import rv_isa_pkg::*;
  import trace_pkg::*;

  logic [`TRACE_NUM_HARTS-1:0] dec_push;
  logic [`TRACE_NUM_HARTS-1:0] ex_adv;
  logic [`TRACE_NUM_HARTS-1:0] wb_adv;
  decode_rec_t                 dec_rec;
  logic                        mem_valid;
  logic                        cap_mem_we;
  xlen_t                       cap_mem_addr;
  logic                        reg_we;
  reg_addr_t                   reg_addr;
  xlen_t                       reg_wdata;
  logic [`TRACE_NUM_HARTS-1:0] ret_valid;
  logic [`TRACE_NUM_HARTS-1:0] ret_pop;
  retire_rec_t                 ret_rec [`TRACE_NUM_HARTS];

  // --------------------
  // Bus capture, one cycle
  trace_capture u_capture (
    .clk_i, .rst_n,
    .id_fire, .id_hart, .id_pc, .id_instr, .id_illegal,
    .ex_fire, .ex_hart, .mem_fire, .mem_we, .mem_addr,
    .wb_fire, .wb_hart, .wb_reg_we, .wb_reg_addr, .wb_reg_wdata,
    .dec_push, .ex_adv, .wb_adv, .dec_rec,
    .mem_valid, .cap_mem_we, .cap_mem_addr,
    .reg_we, .reg_addr, .reg_wdata
  );

  // One tracker per hart, all sharing the captured data
  for (genvar h = 0; h < `TRACE_NUM_HARTS; h++) begin : g_hart
    hart_tracker u_tracker (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .dec_push  (dec_push[h]),
      .ex_adv    (ex_adv[h]),
      .wb_adv    (wb_adv[h]),
      .dec_rec   (dec_rec),
      .mem_valid (mem_valid),
      .mem_we    (cap_mem_we),
      .mem_addr  (cap_mem_addr),
      .reg_we    (reg_we),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .ret_pop   (ret_pop[h]),
      .ret_valid (ret_valid[h]),
      .ret_rec   (ret_rec[h]),
      .overflow  (trace_overflow[h])
    );
  end

  // Output side
  retire_arbiter u_arbiter (
    .clk_i, .rst_n, .ret_valid, .ret_rec, .trace_ack, .ret_pop,
    .trace_req, .trace_hart, .trace_cycle, .trace_pc, .trace_instr, .trace_kind,
    .trace_rd_we, .trace_rd, .trace_rd_wdata,
    .trace_mem_valid, .trace_mem_we, .trace_mem_addr
  );

endmodule

`default_nettype wire

//--- tests/trace_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_cfg.svh"

module trace_unit_tb;

  import rv_isa_pkg::*;
  import trace_pkg::*;

  localparam int OVF_ROWS = `TRACE_FIFO_DEPTH + 2;
  localparam int NROWS    = 14 + OVF_ROWS;
  localparam int TIMEOUT  = 200;

  // One instruction as the cores report it on the bus
  typedef struct {
    int          hart;
    xlen_t       pc;
    xlen_t       instr;
    logic        illegal;
    logic        mem_fire;
    logic        mem_we;
    xlen_t       mem_addr;
    logic        reg_we;
    reg_addr_t   reg_addr;
    xlen_t       reg_wdata;
    instr_kind_e kind;
    logic        lost;
  } row_t;

  // Record the receiver should see
  typedef struct {
    int          hart;
    cycle_t      cycle;
    xlen_t       pc;
    xlen_t       instr;
    instr_kind_e kind;
    logic        rd_we;
    reg_addr_t   rd;
    xlen_t       rd_wdata;
    logic        mem_valid;
    logic        mem_we;
    xlen_t       mem_addr;
  } exp_t;

  logic                        clk_i;
  logic                        rst_n;
  logic                        id_fire;
  hart_id_t                    id_hart;
  xlen_t                       id_pc;
  xlen_t                       id_instr;
  logic                        id_illegal;
  logic                        ex_fire;
  hart_id_t                    ex_hart;
  logic                        mem_fire;
  logic                        mem_we;
  xlen_t                       mem_addr;
  logic                        wb_fire;
  hart_id_t                    wb_hart;
  logic                        wb_reg_we;
  reg_addr_t                   wb_reg_addr;
  xlen_t                       wb_reg_wdata;
  logic                        trace_req;
  logic                        trace_ack;
  hart_id_t                    trace_hart;
  cycle_t                      trace_cycle;
  xlen_t                       trace_pc;
  xlen_t                       trace_instr;
  instr_kind_e                 trace_kind;
  logic                        trace_rd_we;
  reg_addr_t                   trace_rd;
  xlen_t                       trace_rd_wdata;
  logic                        trace_mem_valid;
  logic                        trace_mem_we;
  xlen_t                       trace_mem_addr;
  logic [`TRACE_NUM_HARTS-1:0] trace_overflow;

  row_t        tbl [NROWS];
  exp_t        exp_q [$];
  cycle_t      cyc;
  logic [15:0] lfsr;
  int          errors;
  int          records;
  int          tests;
  int          err0;
  int          rec0;
  string       cur_test;
  logic        req_seen;
  logic        ack_seen;

  trace_unit dut_i (.*);

  always #2 clk_i = ~clk_i;

  // Own cycle count starting at 0 on the first edge after reset release
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) cyc <= '0;
    else cyc <= cyc + 1'b1;
  end

  // Request must never rise while the receiver still holds ack
  always @(posedge clk_i) begin
    if (rst_n && trace_req && !req_seen && ack_seen) begin
      $display("handshake broken in test %s: trace_req rose with trace_ack high", cur_test);
      errors++;
    end
    req_seen <= trace_req;
    ack_seen <= trace_ack;
  end

  // --------------------
  // Helpers
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    // Taps 16 14 13 11
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  function automatic exp_t expect_row(input row_t r, input cycle_t stamp);
    exp_t      e;
    reg_addr_t rd;
    rd = r.instr[11:7];
    e.hart = r.hart;
    e.cycle = stamp;
    e.pc = r.pc;
    e.instr = r.instr;
    e.kind = r.kind;
    e.rd = rd;
    // Write kept only for a matching nonzero destination
    e.rd_we = r.reg_we && (r.reg_addr == rd) && (rd != 5'd0);
    e.rd_wdata = e.rd_we ? r.reg_wdata : '0;
    // No access means all memory fields read zero
    e.mem_valid = r.mem_fire;
    e.mem_we = r.mem_fire && r.mem_we;
    e.mem_addr = r.mem_fire ? r.mem_addr : '0;
    return e;
  endfunction

  function automatic int count_expected(input int first, input int n);
    int i;
    int c;
    c = 0;
    for (i = first; i < first + n; i++) begin
      if (!tbl[i].illegal && !tbl[i].lost) c++;
    end
    return c;
  endfunction

  task automatic init_table();
    int k;
    // hart, pc, instr, illegal, mem fire/we/addr, reg we/addr/wdata, kind, lost
    tbl[0]  = '{0, 32'h1000, 32'h00100293, 0, 0, 0, 32'h0, 1, 5'd5, 32'h1, KIND_ALU, 0};
    tbl[1]  = '{1, 32'h2000, 32'h00052303, 0, 1, 0, 32'h100, 1, 5'd6, 32'hdeadbeef, KIND_LOAD, 0};
    tbl[2]  = '{0, 32'h1004, 32'h00000000, 1, 0, 0, 32'h0, 0, 5'd0, 32'h0, KIND_OTHER, 0};
    tbl[3]  = '{0, 32'h1004, 32'h00652223, 0, 1, 1, 32'h104, 0, 5'd0, 32'h0, KIND_STORE, 0};
    tbl[4]  = '{1, 32'h2004, 32'h006283b3, 0, 0, 0, 32'h0, 1, 5'd7, 32'h55, KIND_ALU, 0};
    // Write to x0 is never kept
    tbl[5]  = '{1, 32'h2008, 32'h00000013, 0, 0, 0, 32'h0, 1, 5'd0, 32'h99, KIND_ALU, 0};
    tbl[6]  = '{0, 32'h1008, 32'h12345437, 0, 0, 0, 32'h0, 1, 5'd8, 32'h12345000, KIND_ALU, 0};
    // Writeback address differs from rd
    tbl[7]  = '{1, 32'h200c, 32'h00148493, 0, 0, 0, 32'h0, 1, 5'd10, 32'h7, KIND_ALU, 0};
    tbl[8]  = '{0, 32'h100c, 32'h008000ef, 0, 0, 0, 32'h0, 1, 5'd1, 32'h1010, KIND_OTHER, 0};
    tbl[9]  = '{1, 32'h2010, 32'hffffffff, 1, 0, 0, 32'h0, 0, 5'd0, 32'h0, KIND_OTHER, 0};
    tbl[10] = '{0, 32'h1014, 32'h00000063, 0, 0, 0, 32'h0, 0, 5'd0, 32'h0, KIND_OTHER, 0};
    tbl[11] = '{1, 32'h2010, 32'h00001597, 0, 0, 0, 32'h0, 1, 5'd11, 32'h3010, KIND_ALU, 0};
    tbl[12] = '{0, 32'h1018, 32'h00812603, 0, 1, 0, 32'h208, 1, 5'd12, 32'hcafe, KIND_LOAD, 0};
    // Warm-up record ahead of the overflow burst
    tbl[13] = '{1, 32'h2014, 32'h34011073, 0, 0, 0, 32'h0, 0, 5'd0, 32'h0, KIND_OTHER, 0};
    // Burst on hart 0 whose last row finds every slot taken
    for (k = 0; k < OVF_ROWS; k++) begin
      tbl[14 + k] = '{0, 32'h3000 + 32'(4 * k), 32'h00128293, 0, 0, 0, 32'h0, 1, 5'd5,
                      32'h100 + 32'(k), KIND_ALU, (k == OVF_ROWS - 1)};
    end
  endtask

  // --------------------
  // Bus driver with decode then execute then writeback one cycle apart
  task automatic apply_rows(input int first, input int n);
    int s;
    int d;
    int e;
    int w;
    for (s = 0; s < n + 2; s++) begin
      @(posedge clk_i);
      d = first + s;
      e = d - 1;
      w = d - 2;
      id_fire  <= 1'b0;
      ex_fire  <= 1'b0;
      mem_fire <= 1'b0;
      wb_fire  <= 1'b0;
      if (s < n) begin
        id_fire    <= 1'b1;
        id_hart    <= hart_id_t'(tbl[d].hart);
        id_pc      <= tbl[d].pc;
        id_instr   <= tbl[d].instr;
        id_illegal <= tbl[d].illegal;
        // Sampled at the next edge one count later
        if (!tbl[d].illegal && !tbl[d].lost) begin
          exp_q.push_back(expect_row(tbl[d], cycle_t'(cyc + 1'b1)));
        end
      end
      if (s >= 1 && s <= n && !tbl[e].illegal) begin
        ex_fire  <= 1'b1;
        ex_hart  <= hart_id_t'(tbl[e].hart);
        mem_fire <= tbl[e].mem_fire;
        mem_we   <= tbl[e].mem_we;
        mem_addr <= tbl[e].mem_addr;
      end
      if (s >= 2 && !tbl[w].illegal) begin
        wb_fire      <= 1'b1;
        wb_hart      <= hart_id_t'(tbl[w].hart);
        wb_reg_we    <= tbl[w].reg_we;
        wb_reg_addr  <= tbl[w].reg_addr;
        wb_reg_wdata <= tbl[w].reg_wdata;
      end
    end
    @(posedge clk_i);
    id_fire  <= 1'b0;
    ex_fire  <= 1'b0;
    mem_fire <= 1'b0;
    wb_fire  <= 1'b0;
  endtask

  // --------------------
  // Receiver with random ack delays
  task automatic collect_records(input int n, input logic hold);
    int   got;
    int   t;
    int   d;
    int   i;
    int   idx;
    exp_t e;
    for (got = 0; got < n; got++) begin
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!trace_req && t < TIMEOUT);
      if (!trace_req) begin
        $display("timeout in test %s: no trace_req for record %0d of %0d", cur_test, got + 1, n);
        errors++;
        return;
      end
      // Record has to stay put until acked
      take_bits(3, d);
      repeat (d) @(posedge clk_i);
      // Oldest pending entry of that hart
      idx = -1;
      for (i = 0; i < exp_q.size(); i++) begin
        if (idx < 0 && exp_q[i].hart == int'(trace_hart)) idx = i;
      end
      if (idx < 0) begin
        $display("unexpected record in test %s: hart %0d pc %h", cur_test, trace_hart, trace_pc);
        errors++;
      end else begin
        e = exp_q[idx];
        exp_q.delete(idx);
        check_value("cycle", e.cycle, trace_cycle);
        check_value("pc", e.pc, trace_pc);
        check_value("instr", e.instr, trace_instr);
        check_value("kind", e.kind, trace_kind);
        check_value("rd_we", e.rd_we, trace_rd_we);
        check_value("rd", e.rd, trace_rd);
        check_value("rd_wdata", e.rd_wdata, trace_rd_wdata);
        check_value("mem_valid", e.mem_valid, trace_mem_valid);
        check_value("mem_we", e.mem_we, trace_mem_we);
        check_value("mem_addr", e.mem_addr, trace_mem_addr);
      end
      records++;
      trace_ack <= 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (trace_req && t < TIMEOUT);
      if (trace_req) begin
        $display("timeout in test %s: trace_req stayed high after ack", cur_test);
        errors++;
        return;
      end
      if (!(hold && got == n - 1)) begin
        take_bits(2, d);
        repeat (d) @(posedge clk_i);
        trace_ack <= 1'b0;
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err0 = errors;
    rec0 = records;
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) begin
      $display("test %s lost %0d expected records", cur_test, exp_q.size());
      errors++;
      exp_q.delete();
    end
    $display("test %s: %0d records, %0d errors", cur_test, records - rec0, errors - err0);
    tests++;
  endtask

  task automatic run_rows(input string name, input int first, input int n);
    begin_test(name);
    fork
      apply_rows(first, n);
      collect_records(count_expected(first, n), 1'b0);
    join
    end_test();
  endtask

  // --------------------
  // Test sequence
  initial begin
    int   t;
    int   i;
    logic extra;
    errors = 0;
    records = 0;
    tests = 0;
    begin_test("reset");
    lfsr = 16'd43;
    req_seen = 1'b0;
    ack_seen = 1'b0;
    clk_i = 1'b0;
    rst_n = 1'b0;
    id_fire = 1'b0;
    id_hart = '0;
    id_pc = '0;
    id_instr = '0;
    id_illegal = 1'b0;
    ex_fire = 1'b0;
    ex_hart = '0;
    mem_fire = 1'b0;
    mem_we = 1'b0;
    mem_addr = '0;
    wb_fire = 1'b0;
    wb_hart = '0;
    wb_reg_we = 1'b0;
    wb_reg_addr = '0;
    wb_reg_wdata = '0;
    trace_ack = 1'b0;
    init_table();
    repeat (4) @(posedge clk_i);
    rst_n <= 1'b1;
    @(posedge clk_i);
    check_value("req after reset", 0, trace_req);
    check_value("overflow after reset", 0, trace_overflow);
    end_test();

    // Both harts interleaved with an illegal decode in the middle
    run_rows("decode_order", 0, 7);
    // Register write rule and a second illegal decode
    run_rows("write_rule", 7, 6);

    begin_test("overflow");
    // Warm-up record acked and ack then held high
    fork
      apply_rows(13, 1);
      collect_records(1, 1'b1);
    join
    apply_rows(14, OVF_ROWS);
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!trace_overflow[0] && t < TIMEOUT);
    if (!trace_overflow[0]) begin
      $display("timeout in test %s: trace_overflow[0] never rose", cur_test);
      errors++;
    end
    check_value("overflow hart 1", 0, trace_overflow[1]);
    check_value("req while ack held", 0, trace_req);
    // Queued records drain in order once ack is released
    @(posedge clk_i);
    trace_ack <= 1'b0;
    collect_records(count_expected(14, OVF_ROWS), 1'b0);
    extra = 1'b0;
    for (i = 0; i < 30; i++) begin
      @(posedge clk_i);
      if (trace_req) extra = 1'b1;
    end
    if (extra) begin
      $display("test %s: a record arrived after the dropped one", cur_test);
      errors++;
    end
    check_value("overflow sticky", 1, trace_overflow[0]);
    end_test();

    $display("tests %0d, records %0d, errors %0d", tests, records, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- trace_unit.f
+incdir+src
src/rv_isa_pkg.sv
src/trace_pkg.sv
src/trace_fifo.sv
src/trace_capture.sv
src/hart_tracker.sv
src/retire_arbiter.sv
src/trace_unit.sv
tests/trace_unit_tb.sv
